// File: src/tlb_dma_pkg.sv
// ---------------------------------------------------------------------
// tlb dma package
// shared types and constants for the tlb miss page transfer subsystem
// ---------------------------------------------------------------------
package tlb_dma_pkg;

  // page offset width used when forming physical addresses
  localparam int PAGE_BITS = 12;
  // largest byte count moved by a single dma request
  localparam int MAX_CHUNK = 1024;

  // host or card physical address
  typedef logic [47:0] vaddr_t;
  // virtual page number
  typedef logic [35:0] vpn_t;
  // process id
  typedef logic [5:0]  pid_t;
  // byte count
  typedef logic [27:0] len_t;

  // one tlb miss as handed to a fetch channel
  typedef struct packed {
    vpn_t vpn;
    pid_t pid;
    // total bytes, never zero
    len_t len;
    // raise an interrupt once the miss is done
    logic isr;
  } tlb_miss_t;

  // one request towards the dma engine
  typedef struct packed {
    vaddr_t paddr_host;
    vaddr_t paddr_card;
    len_t   len;
    // completion wanted, set on the last chunk of a miss
    logic   ctl;
    logic   isr;
    pid_t   pid;
  } dma_req_t;

  // completion reported back by the engine
  typedef struct packed {
    pid_t pid;
  } dma_rsp_t;

  // finished miss as seen by the owner of a channel
  typedef struct packed {
    pid_t pid;
    logic isr;
  } miss_cpl_t;

  // sequence queue entry, wr picks the write channel
  typedef struct packed {
    logic isr;
    logic wr;
  } seq_tag_t;

endpackage

// File: src/seq_queue.sv
// ---------------------------------------------------------------------
// sequence queue
// small synchronous fifo, head word visible before the pop
// ---------------------------------------------------------------------
module seq_queue #(
  parameter int DEPTH = 8,
  parameter int WIDTH = 2
) (
  input  logic             aclk,
  input  logic             rst,
  input  logic             push_valid,
  input  logic [WIDTH-1:0] push_data,
  output logic             push_ready,
  input  logic             pop,
  output logic             head_valid,
  output logic [WIDTH-1:0] head_data
);

  // pointer width, kept at one bit for a single entry queue
  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [AW-1:0]    wr_ptr;
  logic [AW-1:0]    rd_ptr;
  logic [CW-1:0]    count;
  logic             do_push;
  logic             do_pop;

  // full and empty both come straight from the occupancy count
  assign push_ready = (int'(count) != DEPTH);
  assign head_valid = (count != '0);
  assign head_data  = mem[rd_ptr];

  assign do_push = push_valid && push_ready;
  assign do_pop  = pop && head_valid;

  // storage array, written only on an accepted push
  always_ff @(posedge aclk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge aclk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // wrap explicitly so depth need not be a power of two
      if (do_push) begin
        wr_ptr <= (int'(wr_ptr) == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (int'(rd_ptr) == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      end
      // simultaneous push and pop leaves the count alone
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

  // the producer must respect push_ready
  assert property (@(posedge aclk) disable iff (rst) push_valid |-> push_ready);
  // nothing may be consumed from an empty queue
  assert property (@(posedge aclk) disable iff (rst) pop |-> head_valid);

endmodule

// File: src/tlb_fetch_req.sv
// ---------------------------------------------------------------------
// tlb fetch request channel
// splits one tlb miss into dma chunks, caps the unfinished misses
// and forwards the miss completion to the channel owner
// ---------------------------------------------------------------------
module tlb_fetch_req #(
  parameter int                  N_OUTSTANDING = 8,
  parameter tlb_dma_pkg::vaddr_t HOST_BASE     = '0,
  parameter tlb_dma_pkg::vaddr_t CARD_BASE     = '0
) (
  input  logic                    aclk,
  input  logic                    rst,
  input  tlb_dma_pkg::tlb_miss_t  miss,
  input  logic                    miss_valid,
  output logic                    miss_ready,
  output tlb_dma_pkg::dma_req_t   req,
  output logic                    req_valid,
  input  logic                    req_ready,
  input  logic                    cpl_done,
  input  tlb_dma_pkg::miss_cpl_t  cpl,
  output logic                    miss_cpl_valid,
  output tlb_dma_pkg::miss_cpl_t  miss_cpl
);

  localparam int                  CW         = $clog2(N_OUTSTANDING + 1);
  localparam tlb_dma_pkg::len_t   CHUNK_LEN  = tlb_dma_pkg::len_t'(tlb_dma_pkg::MAX_CHUNK);
  localparam tlb_dma_pkg::vaddr_t CHUNK_STEP = tlb_dma_pkg::vaddr_t'(tlb_dma_pkg::MAX_CHUNK);

  typedef enum logic {
    ST_IDLE,
    ST_ISSUE
  } state_t;

  state_t              state_q;
  state_t              state_d;
  logic [CW-1:0]       cnt_q;
  logic [CW-1:0]       cnt_d;
  tlb_dma_pkg::vpn_t   vpn_q;
  // bytes still to move after the chunk currently on req
  tlb_dma_pkg::len_t   rem_q;
  // byte offset of the chunk currently on req
  tlb_dma_pkg::vaddr_t off_q;
  tlb_dma_pkg::vpn_t   src_vpn;
  tlb_dma_pkg::len_t   src_len;
  tlb_dma_pkg::vaddr_t src_off;
  tlb_dma_pkg::len_t   chunk_len;
  tlb_dma_pkg::vaddr_t page_addr;
  logic                miss_acc;
  logic                req_acc;
  logic                last_acc;

  assign req_valid = (state_q == ST_ISSUE);
  assign miss_acc  = miss_valid && miss_ready;
  assign req_acc   = req_valid && req_ready;
  assign last_acc  = req_acc && req.ctl;

  // source of the next chunk, the fresh miss or the one in flight
  always_comb begin
    if (state_q == ST_IDLE) begin
      src_vpn = miss.vpn;
      src_len = miss.len;
      src_off = '0;
    end else begin
      src_vpn = vpn_q;
      src_len = rem_q;
      src_off = off_q + CHUNK_STEP;
    end
    chunk_len = (src_len > CHUNK_LEN) ? CHUNK_LEN : src_len;
    page_addr = tlb_dma_pkg::vaddr_t'(src_vpn) << tlb_dma_pkg::PAGE_BITS;
  end

  // next state and unfinished miss count
  always_comb begin
    state_d = state_q;
    if (miss_acc) begin
      state_d = ST_ISSUE;
    end else if (last_acc) begin
      state_d = ST_IDLE;
    end
    cnt_d = cnt_q;
    case ({last_acc, cpl_done})
      2'b10:   cnt_d = cnt_q + 1'b1;
      2'b01:   cnt_d = cnt_q - 1'b1;
      default: cnt_d = cnt_q;
    endcase
  end

  always_ff @(posedge aclk) begin
    if (rst) begin
      state_q        <= ST_IDLE;
      cnt_q          <= '0;
      miss_ready     <= 1'b0;
      miss_cpl_valid <= 1'b0;
    end else begin
      state_q        <= state_d;
      cnt_q          <= cnt_d;
      // registered, so ready comes up one cycle after reset
      miss_ready     <= (state_d == ST_IDLE) && (int'(cnt_d) < N_OUTSTANDING);
      miss_cpl_valid <= cpl_done;
    end
  end

  // chunk payload, loaded on accept and after every non final chunk
  always_ff @(posedge aclk) begin
    if (miss_acc || (req_acc && !req.ctl)) begin
      req.paddr_host <= HOST_BASE + page_addr + src_off;
      req.paddr_card <= CARD_BASE + page_addr + src_off;
      req.len        <= chunk_len;
      req.ctl        <= (src_len == chunk_len);
      off_q          <= src_off;
      rem_q          <= src_len - chunk_len;
    end
    if (miss_acc) begin
      vpn_q   <= miss.vpn;
      req.isr <= miss.isr;
      req.pid <= miss.pid;
    end
    if (cpl_done) begin
      miss_cpl <= cpl;
    end
  end

  // a stalled chunk has to stay put until the arbiter takes it
  assert property (@(posedge aclk) disable iff (rst)
    req_valid && !req_ready |=> req_valid && $stable(req));
  // completions only ever close a miss that was issued
  assert property (@(posedge aclk) disable iff (rst) cpl_done |-> cnt_q != '0);

endmodule

// File: src/tlb_idma_arb.sv
// ---------------------------------------------------------------------
// tlb idma arbiter
// puts the read or write channel on the dma port under mutex and
// routes in order completions back through a sequence queue
// ---------------------------------------------------------------------
module tlb_idma_arb #(
  parameter int N_OUTSTANDING = 8
) (
  input  logic                    aclk,
  input  logic                    rst,
  // 1 grants the write channel, 0 the read channel
  input  logic                    mutex,
  input  tlb_dma_pkg::dma_req_t   rd_req,
  input  logic                    rd_req_valid,
  output logic                    rd_req_ready,
  input  tlb_dma_pkg::dma_req_t   wr_req,
  input  logic                    wr_req_valid,
  output logic                    wr_req_ready,
  output tlb_dma_pkg::dma_req_t   dma_req,
  output logic                    dma_valid,
  input  logic                    dma_ready,
  input  logic                    dma_done,
  input  tlb_dma_pkg::dma_rsp_t   dma_rsp,
  output logic                    rd_cpl_done,
  output logic                    wr_cpl_done,
  output tlb_dma_pkg::miss_cpl_t  rd_cpl,
  output tlb_dma_pkg::miss_cpl_t  wr_cpl
);

  localparam int TAG_W = $bits(tlb_dma_pkg::seq_tag_t);

  tlb_dma_pkg::dma_req_t   grant_req;
  logic                    grant_valid;
  logic                    seq_push_valid;
  logic                    seq_push_ready;
  tlb_dma_pkg::seq_tag_t   seq_push_tag;
  logic                    seq_head_valid;
  tlb_dma_pkg::seq_tag_t   seq_head_tag;

  // one tag per request that expects a completion
  seq_queue #(
    .DEPTH (N_OUTSTANDING),
    .WIDTH (TAG_W)
  ) u_seq_queue (
    .aclk       (aclk),
    .rst        (rst),
    .push_valid (seq_push_valid),
    .push_data  (seq_push_tag),
    .push_ready (seq_push_ready),
    .pop        (dma_done),
    .head_valid (seq_head_valid),
    .head_data  (seq_head_tag)
  );

  // request side, purely combinational
  always_comb begin
    if (mutex) begin
      grant_req   = wr_req;
      grant_valid = wr_req_valid;
    end else begin
      grant_req   = rd_req;
      grant_valid = rd_req_valid;
    end

    // hold everything back while the tag queue is full
    // so no completion can ever lose its owner
    dma_req      = grant_req;
    dma_valid    = grant_valid && seq_push_ready;
    rd_req_ready = !mutex && dma_ready && seq_push_ready;
    wr_req_ready = mutex && dma_ready && seq_push_ready;

    // only the last chunk of a miss carries ctl
    seq_push_valid   = dma_valid && dma_ready && grant_req.ctl;
    seq_push_tag.isr = grant_req.isr;
    seq_push_tag.wr  = mutex;
  end

  // completion side, the head tag names the owner
  always_comb begin
    rd_cpl_done = dma_done && !seq_head_tag.wr;
    wr_cpl_done = dma_done && seq_head_tag.wr;

    // pid comes from the engine, isr was remembered at issue
    rd_cpl.pid  = dma_rsp.pid;
    rd_cpl.isr  = seq_head_tag.isr;
    wr_cpl.pid  = dma_rsp.pid;
    wr_cpl.isr  = seq_head_tag.isr;
  end

  // the engine may only complete requests that were issued with ctl
  assert property (@(posedge aclk) disable iff (rst) dma_done |-> seq_head_valid);

endmodule

// File: src/tlb_dma_top.sv
// ---------------------------------------------------------------------
// tlb dma top
// read and write fetch channels sharing one dma request port
// ---------------------------------------------------------------------
module tlb_dma_top #(
  parameter int                  N_OUTSTANDING = 8,
  parameter tlb_dma_pkg::vaddr_t RD_HOST_BASE  = 48'h0000_1000_0000,
  parameter tlb_dma_pkg::vaddr_t RD_CARD_BASE  = 48'h0000_2000_0000,
  parameter tlb_dma_pkg::vaddr_t WR_HOST_BASE  = 48'h0000_3000_0000,
  parameter tlb_dma_pkg::vaddr_t WR_CARD_BASE  = 48'h0000_4000_0000
) (
  input  logic                    aclk,
  input  logic                    rst,
  input  logic                    mutex,
  // miss inputs
  input  tlb_dma_pkg::tlb_miss_t  rd_miss,
  input  logic                    rd_miss_valid,
  output logic                    rd_miss_ready,
  input  tlb_dma_pkg::tlb_miss_t  wr_miss,
  input  logic                    wr_miss_valid,
  output logic                    wr_miss_ready,
  // shared dma engine port
  output tlb_dma_pkg::dma_req_t   dma_req,
  output logic                    dma_valid,
  input  logic                    dma_ready,
  input  logic                    dma_done,
  input  tlb_dma_pkg::dma_rsp_t   dma_rsp,
  // finished misses per channel
  output logic                    rd_cpl_valid,
  output tlb_dma_pkg::miss_cpl_t  rd_cpl,
  output logic                    wr_cpl_valid,
  output tlb_dma_pkg::miss_cpl_t  wr_cpl
);

  tlb_dma_pkg::dma_req_t  rd_req;
  logic                   rd_req_valid;
  logic                   rd_req_ready;
  tlb_dma_pkg::dma_req_t  wr_req;
  logic                   wr_req_valid;
  logic                   wr_req_ready;
  logic                   rd_cpl_done;
  logic                   wr_cpl_done;
  tlb_dma_pkg::miss_cpl_t rd_arb_cpl;
  tlb_dma_pkg::miss_cpl_t wr_arb_cpl;

  // read miss channel
  tlb_fetch_req #(
    .N_OUTSTANDING (N_OUTSTANDING),
    .HOST_BASE     (RD_HOST_BASE),
    .CARD_BASE     (RD_CARD_BASE)
  ) u_rd_fetch (
    .aclk           (aclk),
    .rst            (rst),
    .miss           (rd_miss),
    .miss_valid     (rd_miss_valid),
    .miss_ready     (rd_miss_ready),
    .req            (rd_req),
    .req_valid      (rd_req_valid),
    .req_ready      (rd_req_ready),
    .cpl_done       (rd_cpl_done),
    .cpl            (rd_arb_cpl),
    .miss_cpl_valid (rd_cpl_valid),
    .miss_cpl       (rd_cpl)
  );

  // write miss channel
  tlb_fetch_req #(
    .N_OUTSTANDING (N_OUTSTANDING),
    .HOST_BASE     (WR_HOST_BASE),
    .CARD_BASE     (WR_CARD_BASE)
  ) u_wr_fetch (
    .aclk           (aclk),
    .rst            (rst),
    .miss           (wr_miss),
    .miss_valid     (wr_miss_valid),
    .miss_ready     (wr_miss_ready),
    .req            (wr_req),
    .req_valid      (wr_req_valid),
    .req_ready      (wr_req_ready),
    .cpl_done       (wr_cpl_done),
    .cpl            (wr_arb_cpl),
    .miss_cpl_valid (wr_cpl_valid),
    .miss_cpl       (wr_cpl)
  );

  tlb_idma_arb #(
    .N_OUTSTANDING (N_OUTSTANDING)
  ) u_arb (
    .aclk         (aclk),
    .rst          (rst),
    .mutex        (mutex),
    .rd_req       (rd_req),
    .rd_req_valid (rd_req_valid),
    .rd_req_ready (rd_req_ready),
    .wr_req       (wr_req),
    .wr_req_valid (wr_req_valid),
    .wr_req_ready (wr_req_ready),
    .dma_req      (dma_req),
    .dma_valid    (dma_valid),
    .dma_ready    (dma_ready),
    .dma_done     (dma_done),
    .dma_rsp      (dma_rsp),
    .rd_cpl_done  (rd_cpl_done),
    .wr_cpl_done  (wr_cpl_done),
    .rd_cpl       (rd_arb_cpl),
    .wr_cpl       (wr_arb_cpl)
  );

endmodule

// File: verif/tb_tlb_dma_tests.svh
// ---------------------------------------------------------------------
// tlb dma directed tests
// one task per behavior, each drives the DUT and scores the result
// ---------------------------------------------------------------------

// 2500 bytes on the read channel gives 1024, 1024 and 452
task automatic test_read_split();
  tlb_dma_pkg::tlb_miss_t m;
  $display("test: read miss split into chunks");
  @(posedge aclk);
  mutex <= 1'b0;
  m = make_miss(36'h0_0004_2a31, 6'h15, 28'd2500, 1'b1);
  send_miss(1'b0, m);
  wait_drained();
  compare_results();
endtask

// read miss parked while the write channel owns the port
task automatic test_write_grant();
  tlb_dma_pkg::tlb_miss_t m;
  $display("test: write grant blocks the read channel");
  @(posedge aclk);
  mutex <= 1'b1;
  m = make_miss(36'h55, 6'h21, 28'd2048, 1'b1);
  send_miss(1'b0, m);
  m = make_miss(36'h66, 6'h22, 28'd1500, 1'b0);
  send_miss(1'b1, m);
  while (got_wr_cpl.size() < exp_wr_cpl.size()) begin
    @(posedge aclk);
    if (dma_valid && dma_req.paddr_host == exp_rd_req[0].paddr_host) begin
      flag_error("read chunk offered while the write channel holds the grant");
    end
  end
  if (rd_seen.size() != 0 || got_rd_cpl.size() != 0) begin
    flag_error("read channel made progress without the grant");
  end
  // hand the port back, the parked read miss has to finish now
  @(posedge aclk);
  mutex <= 1'b0;
  wait_drained();
  compare_results();
endtask

// alternate channels so completions interleave
task automatic test_cpl_routing();
  tlb_dma_pkg::tlb_miss_t m;
  int i;
  bit wr;
  $display("test: completion routing");
  for (i = 0; i < 6; i++) begin
    wr = i[0];
    @(posedge aclk);
    mutex <= wr;
    m = make_miss(tlb_dma_pkg::vpn_t'(36'h300 + i), tlb_dma_pkg::pid_t'(10 + i),
                  tlb_dma_pkg::len_t'(300 + 700 * i), i[1]);
    send_miss(wr, m);
    // all chunks out before the grant moves on
    wait_issued();
  end
  wait_drained();
  compare_results();
endtask

task automatic test_backpressure();
  tlb_dma_pkg::tlb_miss_t m;
  $display("test: back-pressure");
  @(posedge aclk);
  mutex <= 1'b0;
  ready_random = 1'b1;
  check_stable = 1'b1;
  m = make_miss(36'h400, 6'h31, 28'd3000, 1'b0);
  send_miss(1'b0, m);
  m = make_miss(36'h401, 6'h32, 28'd1024, 1'b1);
  send_miss(1'b0, m);
  m = make_miss(36'h402, 6'h33, 28'd1, 1'b0);
  send_miss(1'b0, m);
  m = make_miss(36'h403, 6'h34, 28'd2100, 1'b1);
  send_miss(1'b0, m);
  wait_drained();
  ready_random = 1'b0;
  check_stable = 1'b0;
  compare_results();
endtask

// completions held back until the channel runs out of credit
task automatic test_outstanding();
  tlb_dma_pkg::tlb_miss_t m;
  int i;
  $display("test: outstanding limit");
  hold_cpl    = 1'b1;
  release_cnt = 0;
  @(posedge aclk);
  mutex <= 1'b0;
  for (i = 0; i < N_OUT; i++) begin
    m = make_miss(tlb_dma_pkg::vpn_t'(36'h500 + i), tlb_dma_pkg::pid_t'(40 + i),
                  28'd64, i[0]);
    send_miss(1'b0, m);
  end
  while (pend_pid.size() < N_OUT) begin
    @(posedge aclk);
  end
  repeat (10) begin
    @(posedge aclk);
    if (rd_miss_ready) begin
      flag_error("read channel ready with all misses outstanding");
    end
  end
  // a single dma_done frees room for exactly one more miss
  release_cnt = 1;
  m = make_miss(36'h5ff, 6'h3f, 28'd64, 1'b1);
  send_miss(1'b0, m);
  while (pend_pid.size() < N_OUT) begin
    @(posedge aclk);
  end
  if (got_rd_cpl.size() != 1) begin
    flag_error("extra miss accepted without a single completion in between");
  end
  repeat (8) begin
    @(posedge aclk);
    if (rd_miss_ready) begin
      flag_error("read channel ready again after its one freed slot was used");
    end
  end
  hold_cpl = 1'b0;
  wait_drained();
  compare_results();
endtask

task automatic send_random(input bit wr, input int n);
  tlb_dma_pkg::tlb_miss_t m;
  int i;
  for (i = 0; i < n; i++) begin
    m = random_miss();
    send_miss(wr, m);
  end
  if (wr) begin
    wr_sent = 1'b1;
  end else begin
    rd_sent = 1'b1;
  end
endtask

// both channels at once, grant moves at random every cycle
task automatic test_random();
  $display("test: random traffic");
  rd_sent = 1'b0;
  wr_sent = 1'b0;
  fork
    send_random(1'b0, 16);
    send_random(1'b1, 16);
    begin
      while (!(rd_sent && wr_sent && all_issued())) begin
        @(posedge aclk);
        mutex <= 1'($urandom_range(0, 1));
      end
    end
  join
  wait_drained();
  compare_results();
endtask

// File: verif/tb_tlb_dma.sv
// ---------------------------------------------------------------------
// tlb dma testbench
// drives both miss channels, models the dma engine and scores the
// requests and completions against the chunk rule
// ---------------------------------------------------------------------
module tb_tlb_dma;

  localparam int N_OUT   = 8;
  localparam int N_TESTS = 6;
  localparam logic [31:0] SEED = 32'h375368de;
  // bases kept far apart so read and write chunks never look alike
  localparam tlb_dma_pkg::vaddr_t RD_HOST = 48'h0000_1100_0000;
  localparam tlb_dma_pkg::vaddr_t RD_CARD = 48'h0000_2200_0000;
  localparam tlb_dma_pkg::vaddr_t WR_HOST = 48'h0000_3300_0000;
  localparam tlb_dma_pkg::vaddr_t WR_CARD = 48'h0000_4400_0000;

  logic                   aclk;
  logic                   rst;
  logic                   mutex;
  tlb_dma_pkg::tlb_miss_t rd_miss;
  logic                   rd_miss_valid;
  logic                   rd_miss_ready;
  tlb_dma_pkg::tlb_miss_t wr_miss;
  logic                   wr_miss_valid;
  logic                   wr_miss_ready;
  tlb_dma_pkg::dma_req_t  dma_req;
  logic                   dma_valid;
  logic                   dma_ready;
  logic                   dma_done;
  tlb_dma_pkg::dma_rsp_t  dma_rsp;
  logic                   rd_cpl_valid;
  tlb_dma_pkg::miss_cpl_t rd_cpl;
  logic                   wr_cpl_valid;
  tlb_dma_pkg::miss_cpl_t wr_cpl;

  // expected and observed traffic per channel
  tlb_dma_pkg::dma_req_t  exp_rd_req[$];
  tlb_dma_pkg::dma_req_t  exp_wr_req[$];
  tlb_dma_pkg::dma_req_t  rd_seen[$];
  tlb_dma_pkg::dma_req_t  wr_seen[$];
  tlb_dma_pkg::miss_cpl_t exp_rd_cpl[$];
  tlb_dma_pkg::miss_cpl_t exp_wr_cpl[$];
  tlb_dma_pkg::miss_cpl_t got_rd_cpl[$];
  tlb_dma_pkg::miss_cpl_t got_wr_cpl[$];
  // channel of each completion with 1 for write
  bit                     exp_order[$];
  bit                     got_order[$];
  // pids of ctl requests still waiting for their dma_done
  tlb_dma_pkg::pid_t      pend_pid[$];

  int val_errs   = 0;
  int other_errs = 0;
  int budget     = 200 * N_TESTS;
  int cycles     = 0;

  // engine controls set by the tests
  bit hold_cpl     = 1'b0;
  int release_cnt  = 0;
  bit ready_random = 1'b0;
  bit check_stable = 1'b0;
  bit rd_sent      = 1'b0;
  bit wr_sent      = 1'b0;

  // engine internal state
  bit                    stall_seen = 1'b0;
  tlb_dma_pkg::dma_req_t stall_req;
  bit                    rdy_level  = 1'b1;
  int                    span       = 0;
  bit                    fire;

  tlb_dma_top #(
    .N_OUTSTANDING (N_OUT),
    .RD_HOST_BASE  (RD_HOST),
    .RD_CARD_BASE  (RD_CARD),
    .WR_HOST_BASE  (WR_HOST),
    .WR_CARD_BASE  (WR_CARD)
  ) u_dut (
    .aclk          (aclk),
    .rst           (rst),
    .mutex         (mutex),
    .rd_miss       (rd_miss),
    .rd_miss_valid (rd_miss_valid),
    .rd_miss_ready (rd_miss_ready),
    .wr_miss       (wr_miss),
    .wr_miss_valid (wr_miss_valid),
    .wr_miss_ready (wr_miss_ready),
    .dma_req       (dma_req),
    .dma_valid     (dma_valid),
    .dma_ready     (dma_ready),
    .dma_done      (dma_done),
    .dma_rsp       (dma_rsp),
    .rd_cpl_valid  (rd_cpl_valid),
    .rd_cpl        (rd_cpl),
    .wr_cpl_valid  (wr_cpl_valid),
    .wr_cpl        (wr_cpl)
  );

  initial begin
    aclk = 1'b0;
    forever #2 aclk = ~aclk;
  end

  task automatic check_req(input string name, input tlb_dma_pkg::dma_req_t got,
                           input tlb_dma_pkg::dma_req_t exp);
    if (got !== exp) begin
      $display("[FAIL] %s got %h expected %h at %0t", name, got, exp, $time);
      val_errs++;
    end
  endtask

  task automatic check_cpl(input string name, input tlb_dma_pkg::miss_cpl_t got,
                           input tlb_dma_pkg::miss_cpl_t exp);
    if (got !== exp) begin
      $display("[FAIL] %s got %h expected %h at %0t", name, got, exp, $time);
      val_errs++;
    end
  endtask

  task automatic flag_error(input string msg);
    $display("ERROR at %0t: %s", $time, msg);
    other_errs++;
  endtask

  // dma engine model that records what it takes and completes ctl requests in order
  initial begin : dma_engine
    dma_ready = 1'b0;
    dma_done  = 1'b0;
    dma_rsp   = '0;
    forever begin
      @(posedge aclk);
      if (rst) begin
        dma_ready <= 1'b0;
        dma_done  <= 1'b0;
      end else begin
        // a request refused last cycle must still be there unchanged
        if (check_stable && stall_seen) begin
          if (!dma_valid) begin
            flag_error("request withdrawn while the engine held it back");
          end else begin
            check_req("dma_req while stalled", dma_req, stall_req);
          end
        end
        stall_seen = dma_valid && !dma_ready;
        stall_req  = dma_req;
        if (dma_valid && dma_ready) begin
          if (mutex) begin
            wr_seen.push_back(dma_req);
          end else begin
            rd_seen.push_back(dma_req);
          end
          if (dma_req.ctl) begin
            pend_pid.push_back(dma_req.pid);
            exp_order.push_back(mutex);
          end
        end
        // at most one completion per cycle after a random wait
        dma_done <= 1'b0;
        fire = 1'b0;
        if (pend_pid.size() != 0) begin
          if (hold_cpl) begin
            fire = (release_cnt > 0);
          end else begin
            fire = ($urandom_range(0, 2) == 0);
          end
        end
        if (fire) begin
          dma_done    <= 1'b1;
          dma_rsp.pid <= pend_pid.pop_front();
          if (hold_cpl) begin
            release_cnt--;
          end
        end
        if (ready_random) begin
          if (span == 0) begin
            rdy_level = ~rdy_level;
            span      = $urandom_range(1, 6);
          end
          span--;
          dma_ready <= rdy_level;
        end else begin
          dma_ready <= 1'b1;
        end
      end
    end
  end

  // completion monitor
  initial begin : cpl_monitor
    forever begin
      @(posedge aclk);
      if (!rst && rd_cpl_valid) begin
        got_rd_cpl.push_back(rd_cpl);
        got_order.push_back(1'b0);
      end
      if (!rst && wr_cpl_valid) begin
        got_wr_cpl.push_back(wr_cpl);
        got_order.push_back(1'b1);
      end
    end
  end

  // limit grows with every chunk the tests expect
  initial begin : watchdog
    while (cycles <= budget) begin
      @(posedge aclk);
      cycles++;
    end
    $display("timeout: the run made no progress within %0d cycles", cycles);
    $display("TEST FAILED");
    $finish;
  end

  function automatic tlb_dma_pkg::tlb_miss_t make_miss(input tlb_dma_pkg::vpn_t vpn,
      input tlb_dma_pkg::pid_t pid, input tlb_dma_pkg::len_t len, input logic isr);
    tlb_dma_pkg::tlb_miss_t m;
    m.vpn = vpn;
    m.pid = pid;
    m.len = len;
    m.isr = isr;
    return m;
  endfunction

  function automatic tlb_dma_pkg::tlb_miss_t random_miss();
    tlb_dma_pkg::tlb_miss_t m;
    m.vpn = tlb_dma_pkg::vpn_t'({$urandom, $urandom});
    m.pid = tlb_dma_pkg::pid_t'($urandom);
    m.len = tlb_dma_pkg::len_t'($urandom_range(1, 4096));
    m.isr = 1'($urandom_range(0, 1));
    return m;
  endfunction

  // ceil(len / MAX_CHUNK) chunks per miss with the remainder in the last one
  task automatic add_expected(input bit wr, input tlb_dma_pkg::tlb_miss_t m);
    tlb_dma_pkg::dma_req_t  r;
    tlb_dma_pkg::miss_cpl_t c;
    tlb_dma_pkg::vaddr_t    page;
    int n;
    int k;
    n    = (int'(m.len) + tlb_dma_pkg::MAX_CHUNK - 1) / tlb_dma_pkg::MAX_CHUNK;
    page = tlb_dma_pkg::vaddr_t'(m.vpn) << tlb_dma_pkg::PAGE_BITS;
    for (k = 0; k < n; k++) begin
      r.paddr_host = (wr ? WR_HOST : RD_HOST) + page
                     + tlb_dma_pkg::vaddr_t'(k * tlb_dma_pkg::MAX_CHUNK);
      r.paddr_card = (wr ? WR_CARD : RD_CARD) + page
                     + tlb_dma_pkg::vaddr_t'(k * tlb_dma_pkg::MAX_CHUNK);
      if (k == n - 1) begin
        r.len = tlb_dma_pkg::len_t'(int'(m.len) - k * tlb_dma_pkg::MAX_CHUNK);
      end else begin
        r.len = tlb_dma_pkg::len_t'(tlb_dma_pkg::MAX_CHUNK);
      end
      r.ctl = (k == n - 1);
      r.isr = m.isr;
      r.pid = m.pid;
      if (wr) begin
        exp_wr_req.push_back(r);
      end else begin
        exp_rd_req.push_back(r);
      end
    end
    c.pid = m.pid;
    c.isr = m.isr;
    if (wr) begin
      exp_wr_cpl.push_back(c);
    end else begin
      exp_rd_cpl.push_back(c);
    end
    budget += 50 * n;
  endtask

  // offer one miss and hold it until the channel takes it
  task automatic send_miss(input bit wr, input tlb_dma_pkg::tlb_miss_t m);
    add_expected(wr, m);
    @(posedge aclk);
    if (wr) begin
      wr_miss       <= m;
      wr_miss_valid <= 1'b1;
    end else begin
      rd_miss       <= m;
      rd_miss_valid <= 1'b1;
    end
    do begin
      @(posedge aclk);
    end while (!(wr ? wr_miss_ready : rd_miss_ready));
    if (wr) begin
      wr_miss_valid <= 1'b0;
    end else begin
      rd_miss_valid <= 1'b0;
    end
  endtask

  function automatic bit all_issued();
    return (rd_seen.size() >= exp_rd_req.size()) && (wr_seen.size() >= exp_wr_req.size());
  endfunction

  function automatic bit drained();
    return all_issued() && (pend_pid.size() == 0)
           && (got_rd_cpl.size() >= exp_rd_cpl.size())
           && (got_wr_cpl.size() >= exp_wr_cpl.size());
  endfunction

  task automatic wait_issued();
    while (!all_issued()) begin
      @(posedge aclk);
    end
  endtask

  // short settle afterwards so stray extra completions get caught
  task automatic wait_drained();
    while (!drained()) begin
      @(posedge aclk);
    end
    repeat (4) @(posedge aclk);
  endtask

  task automatic compare_results();
    int i;
    if (rd_seen.size() != exp_rd_req.size()) begin
      flag_error($sformatf("read channel issued %0d requests, %0d expected",
                           rd_seen.size(), exp_rd_req.size()));
    end
    for (i = 0; i < rd_seen.size() && i < exp_rd_req.size(); i++) begin
      check_req("rd dma_req", rd_seen[i], exp_rd_req[i]);
    end
    if (wr_seen.size() != exp_wr_req.size()) begin
      flag_error($sformatf("write channel issued %0d requests, %0d expected",
                           wr_seen.size(), exp_wr_req.size()));
    end
    for (i = 0; i < wr_seen.size() && i < exp_wr_req.size(); i++) begin
      check_req("wr dma_req", wr_seen[i], exp_wr_req[i]);
    end
    if (got_rd_cpl.size() != exp_rd_cpl.size()) begin
      flag_error($sformatf("%0d read completions seen, %0d expected",
                           got_rd_cpl.size(), exp_rd_cpl.size()));
    end
    for (i = 0; i < got_rd_cpl.size() && i < exp_rd_cpl.size(); i++) begin
      check_cpl("rd_cpl", got_rd_cpl[i], exp_rd_cpl[i]);
    end
    if (got_wr_cpl.size() != exp_wr_cpl.size()) begin
      flag_error($sformatf("%0d write completions seen, %0d expected",
                           got_wr_cpl.size(), exp_wr_cpl.size()));
    end
    for (i = 0; i < got_wr_cpl.size() && i < exp_wr_cpl.size(); i++) begin
      check_cpl("wr_cpl", got_wr_cpl[i], exp_wr_cpl[i]);
    end
    for (i = 0; i < got_order.size() && i < exp_order.size(); i++) begin
      if (got_order[i] != exp_order[i]) begin
        flag_error($sformatf("completion %0d came out on the wrong channel", i));
      end
    end
    exp_rd_req.delete();
    exp_wr_req.delete();
    rd_seen.delete();
    wr_seen.delete();
    exp_rd_cpl.delete();
    exp_wr_cpl.delete();
    got_rd_cpl.delete();
    got_wr_cpl.delete();
    exp_order.delete();
    got_order.delete();
  endtask

  `include "tb_tlb_dma_tests.svh"

  initial begin : main
    void'($urandom(SEED));
    rst           = 1'b1;
    mutex         = 1'b0;
    rd_miss       = '0;
    rd_miss_valid = 1'b0;
    wr_miss       = '0;
    wr_miss_valid = 1'b0;
    repeat (5) @(posedge aclk);
    rst <= 1'b0;
    @(posedge aclk);
    // nothing may be offered straight out of reset
    if (dma_valid || rd_cpl_valid || wr_cpl_valid || rd_miss_ready || wr_miss_ready) begin
      flag_error("outputs active in the first cycle after reset");
    end
    @(posedge aclk);
    // both idle channels take misses one cycle later
    if (!rd_miss_ready || !wr_miss_ready) begin
      flag_error("miss ready did not rise in the first cycle after reset");
    end
    test_read_split();
    test_write_grant();
    test_cpl_routing();
    test_backpressure();
    test_outstanding();
    test_random();
    $display("errors: %0d value mismatches, %0d other failures", val_errs, other_errs);
    if (val_errs == 0 && other_errs == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: tlb_dma.f
+incdir+verif
src/tlb_dma_pkg.sv
src/seq_queue.sv
src/tlb_fetch_req.sv
src/tlb_idma_arb.sv
src/tlb_dma_top.sv
verif/tb_tlb_dma.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the tlb dma testbench with verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -j 0 \
  --top-module tb_tlb_dma \
  -f tlb_dma.f \
  -o sim_tlb_dma

./obj_dir/sim_tlb_dma | tee sim.log

# the log decides the result, not the exit code of the simulator
if grep -qx "TEST OK" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed, see sim.log"
  exit 1
fi
